//--- Makefile
TOP := mem_sys_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f mem_sys.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

//--- mem_sys.f
+incdir+src
src/mem_sys_pkg.sv
src/mem_req_if.sv
src/mem_bank.sv
src/mem_wait_ctrl.sv
src/mem_cfg_regs.sv
src/mem_sys_top.sv
test/mem_sys_props.sv
test/mem_sys_tb.sv

//--- src/mem_bank.sv
// ==================================================
// storage has no reset and no init file, undefined until written
// lane addresses wrap at the top of memory
// ==================================================

`default_nettype none

`include "mem_sys_settings.svh"

module mem_bank
  import mem_sys_pkg::*;
(
  input  logic    CLK_I,
  input  logic    rst_n,
  mem_req_if.bank req,
  input  addr_t   wp_limit,
  output word_t   dat_r,
  output logic    wr_blocked
);

  localparam int MEM_DEPTH = 1 << `MEM_ADDR_W;

  byte_t mem [MEM_DEPTH];

  addr_t lane_adr [`MEM_LANES];
  // lanes that fall below the protect limit
  sel_t  lane_wp;
  sel_t  wr_ok;

  // ================================================
  // lane address decode
  // ================================================

  always_comb begin
    for (int k = 0; k < `MEM_LANES; k++) begin
      // addr_t width drops the carry, which gives the wrap
      lane_adr[k] = req.adr + addr_t'(k);
      lane_wp[k]  = (lane_adr[k] < wp_limit);
    end
  end

  assign wr_ok = req.sel & ~lane_wp;

  // one pulse per write that lost at least one lane
  assign wr_blocked = req.accept & req.we & (|(req.sel & lane_wp));

  // ================================================
  // write and read ports
  // ================================================

  always_ff @(posedge CLK_I) begin
    if (req.accept && req.we) begin
      for (int k = 0; k < `MEM_LANES; k++) begin
        if (wr_ok[k]) begin
          mem[lane_adr[k]] <= req.dat_w[8*k +: 8];
        end
      end
    end
  end

  // nonblocking read sees the bytes from before a same-edge write
  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      dat_r <= '0;
    end else if (req.accept && req.rd) begin
      for (int k = 0; k < `MEM_LANES; k++) begin
        if (req.sel[k]) begin
          dat_r[8*k +: 8] <= mem[lane_adr[k]];
        end else begin
          dat_r[8*k +: 8] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/mem_cfg_regs.sv
// ==================================================
// index 0 wait count, 1 protect limit, 2 blocked count
// blocked count saturates at 255, a write to index 2 clears it
// ==================================================

`default_nettype none

`include "mem_sys_settings.svh"

module mem_cfg_regs
  import mem_sys_pkg::*;
(
  input  logic     CLK_I,
  input  logic     rst_n,
  input  logic     cfg_we,
  input  cfg_adr_t cfg_adr,
  input  byte_t    cfg_wdata,
  output byte_t    cfg_rdata,
  input  logic     wr_blocked,
  output wait_t    wait_cycles,
  output addr_t    wp_limit
);

  byte_t blk_cnt;

  // ================================================
  // writable registers
  // ================================================

  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      wait_cycles <= wait_t'(`MEM_DEF_WAIT);
      wp_limit    <= '0;
    end else if (cfg_we) begin
      if (cfg_adr == cfg_adr_t'(0)) begin
        wait_cycles <= cfg_wdata[`MEM_WAIT_W-1:0];
      end
      if (cfg_adr == cfg_adr_t'(1)) begin
        wp_limit <= cfg_wdata[`MEM_ADDR_W-1:0];
      end
    end
  end

  // blocked-write counter, clear wins over a same-edge pulse
  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      blk_cnt <= '0;
    end else if (cfg_we && (cfg_adr == cfg_adr_t'(2))) begin
      blk_cnt <= '0;
    end else if (wr_blocked && (blk_cnt != 8'hff)) begin
      blk_cnt <= blk_cnt + 8'd1;
    end
  end

  // ================================================
  // readback
  // ================================================

  always_comb begin
    unique case (cfg_adr)
      2'd0:    cfg_rdata = byte_t'(wait_cycles);
      2'd1:    cfg_rdata = byte_t'(wp_limit);
      2'd2:    cfg_rdata = blk_cnt;
      default: cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mem_req_if.sv
// ==================================================
// accepted access, wait controller to memory bank
// accept is a one-cycle strobe, other fields are raw
// ==================================================

`default_nettype none

interface mem_req_if
  import mem_sys_pkg::*;
  ();

  addr_t adr;
  word_t dat_w;
  sel_t  sel;
  logic  we;
  logic  rd;
  // true in the cycle the access is taken
  logic  accept;

  modport ctrl (
    output adr,
    output dat_w,
    output sel,
    output we,
    output rd,
    output accept
  );

  modport bank (
    input adr,
    input dat_w,
    input sel,
    input we,
    input rd,
    input accept
  );

endinterface

`default_nettype wire

//--- src/mem_sys_pkg.sv
// ==================================================
// types shared by the memory system modules
// widths come from the settings header
// ==================================================

`default_nettype none

`include "mem_sys_settings.svh"

package mem_sys_pkg;

  // one stored byte
  typedef logic [7:0] byte_t;

  // bus data word, lane k in bits 8k+7..8k
  typedef logic [8*`MEM_LANES-1:0] word_t;

  // byte address into storage
  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  // one enable per byte lane
  typedef logic [`MEM_LANES-1:0] sel_t;

  // wait cycle count
  typedef logic [`MEM_WAIT_W-1:0] wait_t;

  // configuration register index
  typedef logic [1:0] cfg_adr_t;

  // wait controller FSM
  typedef enum logic {
    IDLE,
    BUSY
  } wait_state_t;

endpackage

`default_nettype wire

//--- src/mem_sys_settings.svh
// ==================================================
// widths and reset values shared by the memory system
// memory depth follows MEM_ADDR_W, one byte per address
// ==================================================

`ifndef MEM_SYS_SETTINGS_SVH
`define MEM_SYS_SETTINGS_SVH

// byte address width, 32 bytes of storage
`define MEM_ADDR_W 5

// byte lanes per bus word
`define MEM_LANES 4

// wait count width, so at most 15 wait cycles
`define MEM_WAIT_W 4

// wait count loaded at reset
`define MEM_DEF_WAIT 3

`endif

//--- src/mem_sys_top.sv
// ==================================================
// byte-lane data memory with wait states and config block
// single bus master, no bursts and no error response
// ==================================================

`default_nettype none

module mem_sys_top
  import mem_sys_pkg::*;
(
  input  logic     CLK_I,
  input  logic     rst_n,
  // bus side
  input  logic     stb,
  input  logic     we,
  input  logic     rd,
  input  addr_t    adr,
  input  word_t    dat_w,
  input  sel_t     sel,
  output word_t    dat_r,
  output logic     ack,
  // configuration side
  input  logic     cfg_we,
  input  cfg_adr_t cfg_adr,
  input  byte_t    cfg_wdata,
  output byte_t    cfg_rdata
);

  wait_t wait_cycles;
  addr_t wp_limit;
  logic  wr_blocked;

  mem_req_if req_if ();

  mem_wait_ctrl u_wait_ctrl (
    .CLK_I       (CLK_I),
    .rst_n       (rst_n),
    .stb         (stb),
    .we          (we),
    .rd          (rd),
    .adr         (adr),
    .dat_w       (dat_w),
    .sel         (sel),
    .wait_cycles (wait_cycles),
    .ack         (ack),
    .req         (req_if.ctrl)
  );

  mem_bank u_bank (
    .CLK_I      (CLK_I),
    .rst_n      (rst_n),
    .req        (req_if.bank),
    .wp_limit   (wp_limit),
    .dat_r      (dat_r),
    .wr_blocked (wr_blocked)
  );

  mem_cfg_regs u_cfg_regs (
    .CLK_I       (CLK_I),
    .rst_n       (rst_n),
    .cfg_we      (cfg_we),
    .cfg_adr     (cfg_adr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .wr_blocked  (wr_blocked),
    .wait_cycles (wait_cycles),
    .wp_limit    (wp_limit)
  );

endmodule

`default_nettype wire

//--- src/mem_wait_ctrl.sv
// ==================================================
// strobes seen while ack is low are ignored
// host holds stb until ack returns high
// ==================================================

`default_nettype none

module mem_wait_ctrl
  import mem_sys_pkg::*;
(
  input  logic    CLK_I,
  input  logic    rst_n,
  input  logic    stb,
  input  logic    we,
  input  logic    rd,
  input  addr_t   adr,
  input  word_t   dat_w,
  input  sel_t    sel,
  input  wait_t   wait_cycles,
  output logic    ack,
  mem_req_if.ctrl req
);

  wait_state_t state;
  // wait cycles still to go, including the current one
  wait_t       cnt;
  logic        accept;

  // ================================================
  // accept strobe and request fields
  // ================================================

  assign ack    = (state == IDLE);
  assign accept = stb & ack & (we | rd);

  assign req.accept = accept;
  assign req.adr    = adr;
  assign req.dat_w  = dat_w;
  assign req.sel    = sel;
  assign req.we     = we;
  assign req.rd     = rd;

  // ================================================
  // wait state FSM
  // ================================================

  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          // zero wait count keeps ack high
          if (accept && (wait_cycles != '0)) begin
            state <= BUSY;
            cnt   <= wait_cycles;
          end
        end
        BUSY: begin
          // last low cycle, ack is back next cycle
          if (cnt == wait_t'(1)) begin
            state <= IDLE;
          end
          cnt <= cnt - wait_t'(1);
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- test/mem_sys_props.sv
// ==================================================
// timing checks on the top-level bus and config ports
// blocked count is seen through cfg_rdata at index 2
// ==================================================

`default_nettype none

module mem_sys_props
  import mem_sys_pkg::*;
(
  input logic     CLK_I,
  input logic     rst_n,
  input logic     ack,
  input word_t    dat_r,
  input logic     cfg_we,
  input cfg_adr_t cfg_adr,
  input byte_t    cfg_rdata
);

  timeunit 1ns;
  timeprecision 100ps;

  // failing assertions so far
  int fail_cnt = 0;
  // earlier consecutive low samples of ack
  int low_run;

  always_ff @(posedge CLK_I or negedge rst_n) begin
    if (!rst_n) begin
      low_run <= 0;
    end else if (!ack) begin
      low_run <= low_run + 1;
    end else begin
      low_run <= 0;
    end
  end

  // ================================================
  // assertions
  // ================================================

  ack_after_reset: assert property (@(posedge CLK_I) $rose(rst_n) |-> ack)
    else begin
      fail_cnt++;
      $error("ack low in the first cycle after reset");
    end

  // a 4-bit wait count allows at most 15 low cycles
  ack_low_bound: assert property (@(posedge CLK_I) disable iff (!rst_n)
    !ack |-> low_run < 15)
    else begin
      fail_cnt++;
      $error("ack low for more than 15 cycles");
    end

  // no read can load dat_r at an edge where ack is low
  dat_r_stable: assert property (@(posedge CLK_I) disable iff (!rst_n)
    !ack |=> $stable(dat_r))
    else begin
      fail_cnt++;
      $error("dat_r changed while ack was low");
    end

  blk_no_drop: assert property (@(posedge CLK_I) disable iff (!rst_n)
    (cfg_adr == 2'd2 && !cfg_we) |=> (cfg_adr != 2'd2 || cfg_rdata >= $past(cfg_rdata)))
    else begin
      fail_cnt++;
      $error("blocked count dropped without a write");
    end

endmodule

bind mem_sys_top mem_sys_props props0 (
  .CLK_I     (CLK_I),
  .rst_n     (rst_n),
  .ack       (ack),
  .dat_r     (dat_r),
  .cfg_we    (cfg_we),
  .cfg_adr   (cfg_adr),
  .cfg_rdata (cfg_rdata)
);

`default_nettype wire

//--- test/mem_sys_tb.sv
// ==================================================
// self-checking testbench for mem_sys_top, LFSR stimulus
// memory is filled by writes before anything is read back
// ==================================================

`default_nettype none

`include "mem_sys_settings.svh"

module mem_sys_tb
  import mem_sys_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int STIM_DLY   = 2;
  localparam int MEM_DEPTH  = 1 << `MEM_ADDR_W;
  localparam int ACK_LIMIT  = 20;
  // cycle budget per test, wait states included
  localparam int T1_CYC = 10;
  localparam int T2_CYC = 200;
  localparam int T3_CYC = 240;
  localparam int T4_CYC = 210;
  localparam int T5_CYC = 150;
  localparam int WD_CYC = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + 100;

  logic     CLK_I;
  logic     rst_n;
  logic     stb;
  logic     we;
  logic     rd;
  addr_t    adr;
  word_t    dat_w;
  sel_t     sel;
  word_t    dat_r;
  logic     ack;
  logic     cfg_we;
  cfg_adr_t cfg_adr;
  byte_t    cfg_wdata;
  byte_t    cfg_rdata;

  // reference model state
  byte_t       ref_mem [MEM_DEPTH];
  int          exp_wait;
  int          exp_wp;
  int          exp_blk;
  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          prop_errs;
  int          cycles;

  mem_sys_top dut0 (
    .CLK_I     (CLK_I),
    .rst_n     (rst_n),
    .stb       (stb),
    .we        (we),
    .rd        (rd),
    .adr       (adr),
    .dat_w     (dat_w),
    .sel       (sel),
    .dat_r     (dat_r),
    .ack       (ack),
    .cfg_we    (cfg_we),
    .cfg_adr   (cfg_adr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

  always #(CLK_PERIOD / 2) CLK_I = ~CLK_I;

  always @(posedge CLK_I) begin
    cycles <= cycles + 1;
  end

  // ================================================
  // helpers
  // ================================================

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic addr_t lane_addr(input addr_t base, input int k);
    return addr_t'((int'(base) + k) % MEM_DEPTH);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
    end
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic test_done(input int n, input string name);
    $display("test %0d %s finished, %0d errors so far", n, name, errors);
  endtask

  task automatic cfg_write(input cfg_adr_t idx, input byte_t val);
    cfg_we    = 1'b1;
    cfg_adr   = idx;
    cfg_wdata = val;
    @(posedge CLK_I);
    #STIM_DLY;
    cfg_we  = 1'b0;
    // park on the blocked count between accesses
    cfg_adr = 2'd2;
  endtask

  task automatic cfg_check(input cfg_adr_t idx, input int exp, input string name);
    cfg_adr = idx;
    #1;
    check_val(name, 32'(cfg_rdata), exp);
    cfg_adr = 2'd2;
  endtask

  task automatic bus_access(input logic do_we, input logic do_rd, input addr_t a,
                            input word_t d, input sel_t s);
    word_t exp_rd;
    logic  blocked;
    addr_t la;
    int    waits;
    waits = 0;
    while (!ack && waits < ACK_LIMIT) begin
      @(posedge CLK_I);
      #STIM_DLY;
      waits++;
    end
    if (!ack) begin
      report_fail("ack never came back high before an access");
    end
    stb   = 1'b1;
    we    = do_we;
    rd    = do_rd;
    adr   = a;
    dat_w = d;
    sel   = s;
    // read sees the bytes from before a same-edge write
    exp_rd  = '0;
    blocked = 1'b0;
    for (int k = 0; k < `MEM_LANES; k++) begin
      la = lane_addr(a, k);
      if (s[k]) begin
        exp_rd[8*k +: 8] = ref_mem[la];
      end
    end
    for (int k = 0; k < `MEM_LANES; k++) begin
      la = lane_addr(a, k);
      if (do_we && s[k] && int'(la) >= exp_wp) begin
        ref_mem[la] = d[8*k +: 8];
      end else if (do_we && s[k]) begin
        blocked = 1'b1;
      end
    end
    if (blocked && exp_blk < 255) begin
      exp_blk++;
    end
    @(posedge CLK_I);
    #STIM_DLY;
    stb = 1'b0;
    we  = 1'b0;
    rd  = 1'b0;
    if (do_rd) begin
      check_val("dat_r", dat_r, exp_rd);
    end
    waits = 0;
    while (!ack && waits < ACK_LIMIT) begin
      @(posedge CLK_I);
      #STIM_DLY;
      waits++;
    end
    check_val("ack low cycles", waits, exp_wait);
  endtask

  // ================================================
  // tests
  // ================================================

  task automatic check_reset_defaults();
    check_val("ack", 32'(ack), 1);
    check_val("dat_r", dat_r, 0);
    cfg_check(2'd0, `MEM_DEF_WAIT, "cfg_rdata[wait]");
    cfg_check(2'd1, 0, "cfg_rdata[wp_limit]");
    cfg_check(2'd2, 0, "cfg_rdata[blk_cnt]");
  endtask

  task automatic drive_full_words();
    addr_t a;
    for (int i = 0; i < MEM_DEPTH; i += 4) begin
      bus_access(1'b1, 1'b0, addr_t'(i), rand_bits(32), 4'hf);
    end
    for (int i = 0; i < 12; i++) begin
      // the first few start at the top so the lanes wrap
      a = (i < 3) ? addr_t'(29 + i) : addr_t'(rand_bits(`MEM_ADDR_W));
      bus_access(1'b1, 1'b0, a, rand_bits(32), 4'hf);
      a = (i < 3) ? addr_t'(31 - i) : addr_t'(rand_bits(`MEM_ADDR_W));
      bus_access(1'b0, 1'b1, a, '0, 4'hf);
    end
  endtask

  task automatic drive_partial_lanes();
    addr_t a;
    sel_t  s;
    logic  r;
    for (int i = 0; i < 16; i++) begin
      a = addr_t'(rand_bits(`MEM_ADDR_W));
      s = sel_t'(rand_bits(`MEM_LANES));
      r = 1'(rand_bits(1));
      bus_access(1'b1, r, a, rand_bits(32), s);
      bus_access(1'b0, 1'b1, addr_t'(rand_bits(`MEM_ADDR_W)), '0,
                 sel_t'(rand_bits(`MEM_LANES)));
      // full read shows whether unselected bytes survived
      bus_access(1'b0, 1'b1, a, '0, 4'hf);
    end
  endtask

  task automatic measure_wait_states();
    int n_list [3] = '{0, 1, 5};
    int c0;
    foreach (n_list[j]) begin
      cfg_write(2'd0, byte_t'(n_list[j]));
      exp_wait = n_list[j];
      cfg_check(2'd0, exp_wait, "cfg_rdata[wait]");
      c0 = cycles;
      for (int i = 0; i < 6; i++) begin
        bus_access(1'(rand_bits(1)), 1'b1, addr_t'(rand_bits(`MEM_ADDR_W)),
                   rand_bits(32), 4'hf);
      end
      // zero wait means one cycle per access
      if (exp_wait == 0) begin
        check_val("back-to-back cycles", cycles - c0, 6);
      end
    end
    cfg_write(2'd0, byte_t'(`MEM_DEF_WAIT));
    exp_wait = `MEM_DEF_WAIT;
  endtask

  task automatic exercise_write_protect();
    addr_t a;
    addr_t hits [4] = '{5'd2, 5'd30, 5'd12, 5'd6};
    cfg_write(2'd1, 8'd8);
    exp_wp = 8;
    cfg_check(2'd1, 8, "cfg_rdata[wp_limit]");
    for (int i = 0; i < 10; i++) begin
      a = (i < 4) ? hits[i] : addr_t'(rand_bits(`MEM_ADDR_W));
      bus_access(1'b1, 1'b0, a, rand_bits(32), 4'hf);
      cfg_check(2'd2, exp_blk, "cfg_rdata[blk_cnt]");
    end
    for (int i = 0; i < MEM_DEPTH; i += 4) begin
      bus_access(1'b0, 1'b1, addr_t'(i), '0, 4'hf);
    end
    cfg_write(2'd2, 8'd0);
    exp_blk = 0;
    cfg_check(2'd2, 0, "cfg_rdata[blk_cnt]");
    cfg_write(2'd1, 8'd0);
    exp_wp = 0;
  endtask

  // ================================================
  // main sequence and watchdog
  // ================================================

  initial begin
    CLK_I     = 1'b0;
    rst_n     = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    rd        = 1'b0;
    adr       = '0;
    dat_w     = '0;
    sel       = '0;
    cfg_we    = 1'b0;
    cfg_adr   = 2'd2;
    cfg_wdata = '0;
    lfsr      = 32'hb65d_5156;
    checks    = 0;
    errors    = 0;
    cycles    = 0;
    exp_wait  = `MEM_DEF_WAIT;
    exp_wp    = 0;
    exp_blk   = 0;
    repeat (3) @(posedge CLK_I);
    #STIM_DLY;
    rst_n = 1'b1;
    check_reset_defaults();
    test_done(1, "reset defaults");
    drive_full_words();
    test_done(2, "full-word access");
    drive_partial_lanes();
    test_done(3, "partial lane enables");
    measure_wait_states();
    test_done(4, "wait states");
    exercise_write_protect();
    test_done(5, "write protection");
    prop_errs = dut0.props0.fail_cnt;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_errs);
    if (errors == 0 && prop_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(WD_CYC * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WD_CYC);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire
